// File: dv/i2f_tb.sv
`timescale 1ns/10ps

module i2f_tb import i2f_pkg::*; #(
    parameter int LOG2_WIDTH  = DEFAULT_LOG2_WIDTH,
    parameter int MANT_WIDTH  = DEFAULT_MANT_WIDTH,
    parameter int IN_DEPTH    = DEFAULT_IN_DEPTH,
    parameter int OUT_CREDITS = DEFAULT_OUT_CREDITS
);

    localparam int WIDTH          = 2 ** LOG2_WIDTH;
    localparam int REF_W          = 1 + LOG2_WIDTH + MANT_WIDTH;  // {zero, exp, mant}
    localparam int NUM_RANDOM     = 400;
    localparam int STALL_CYCLES   = 100;
    localparam int TIMEOUT_CYCLES = 20 * NUM_RANDOM;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    logic [WIDTH-1:0]      in_data;
    logic                  out_credit;
    logic                  in_credit;
    logic                  out_valid;
    logic                  out_zero;
    logic [LOG2_WIDTH-1:0] out_exp;
    logic [MANT_WIDTH-1:0] out_mant;

    integer           seed;
    logic [WIDTH-1:0] stim [$];
    logic [REF_W-1:0] exp_q [$];
    logic [REF_W-1:0] expected;
    int               sent = 0;
    int               rcvd = 0;
    int               up_credits = IN_DEPTH;   // Upstream view of buffer slots
    int               out_seen = 0;
    int               returned = 0;
    int               owed = 0;                // Words taken but not yet credited back
    int               credit_mode = 0;         // 0 fast, 1 slow, 2 held off
    int               roll;
    int               cycles = 0;
    int               checks = 0;
    int               errors = 0;

    i2f_top #(
        .LOG2_WIDTH  (LOG2_WIDTH),
        .MANT_WIDTH  (MANT_WIDTH),
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i2f_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_zero   (out_zero),
        .out_exp    (out_exp),
        .out_mant   (out_mant)
    );

    always #5 clk = ~clk;

    // ****************************************
    // Reference model and check
    // ****************************************

    function automatic logic bit_at(input logic [WIDTH-1:0] v, input int pos);
        logic [WIDTH-1:0] tmp;
        tmp = v >> pos;
        return tmp[0];
    endfunction

    // Scan from the MSB for the leading one, then copy bits below it
    function automatic logic [REF_W-1:0] ref_convert(input logic [WIDTH-1:0] v);
        logic                  found;
        int                    top;
        logic [MANT_WIDTH-1:0] m;
        found = 1'b0;
        top   = 0;
        m     = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (!found && bit_at(v, i)) begin
                top   = i;
                found = 1'b1;
            end
        end
        for (int j = 0; j < MANT_WIDTH; j++) begin
            m = (m << 1) | MANT_WIDTH'((top - j >= 0) ? bit_at(v, top - j) : 1'b0);
        end
        return {!found, LOG2_WIDTH'(top), m};
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // ****************************************
    // Upstream and downstream models
    // ****************************************

    always @(negedge clk) begin
        if (reset) begin
            in_valid <= 1'b0;
        end else begin
            if (in_credit) up_credits++;
            if (sent < stim.size() && up_credits > 0) begin
                in_valid <= 1'b1;
                in_data  <= stim[sent];
                exp_q.push_back(ref_convert(stim[sent]));
                sent++;
                up_credits--;   // Spent at send
            end else begin
                in_valid <= 1'b0;
            end
            check_value("upstream credit count in range",
                        64'(up_credits >= 0 && up_credits <= IN_DEPTH), 64'(1));
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            out_credit <= 1'b0;
        end else begin
            if (out_valid) begin
                out_seen++;
                owed++;
                check_value("out_valid within granted credits",
                            64'(out_seen <= OUT_CREDITS + returned), 64'(1));
            end
            roll = $random(seed) & 7;
            if (owed > 0 && ((credit_mode == 0 && roll != 0) ||
                             (credit_mode == 1 && roll == 0))) begin
                out_credit <= 1'b1;
                owed--;
                returned++;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // Scoreboard samples outputs away from the rising edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            rcvd++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output word at %0d ns arrived with no word expected", $time);
            end else begin
                expected = exp_q.pop_front();
                check_value("zero flag", 64'(out_zero), 64'(expected[REF_W-1]));
                check_value("exponent", 64'(out_exp),
                            64'(expected[MANT_WIDTH +: LOG2_WIDTH]));
                check_value("mantissa", 64'(out_mant), 64'(expected[MANT_WIDTH-1:0]));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d words received",
                     cycles, rcvd, stim.size());
            $display("Test FAILED");
            $finish;
        end
    end

    // ****************************************
    // Stimulus and run control
    // ****************************************

    initial begin
        logic [WIDTH-1:0] value;
        int               sh;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_credit = 1'b0;
        seed       = 32'h2ff6;

        stim.push_back('0);
        stim.push_back(WIDTH'(1));
        stim.push_back('1);
        for (int k = 0; k < WIDTH; k++) stim.push_back(WIDTH'(1) << k);
        for (int k = 1; k <= WIDTH; k++) stim.push_back({WIDTH{1'b1}} >> (WIDTH - k));
        for (int n = 0; n < NUM_RANDOM; n++) begin
            value = WIDTH'($random(seed));
            sh    = $random(seed) & (WIDTH - 1);  // Spread the leading one
            stim.push_back(value >> sh);
        end

        repeat (5) @(negedge clk);
        reset <= 1'b0;

        while (sent < 150) @(posedge clk);
        credit_mode <= 1;
        while (sent < 250) @(posedge clk);
        credit_mode <= 2;   // Long stretch with no downstream credits
        repeat (STALL_CYCLES) @(posedge clk);
        credit_mode <= 0;

        while (!(sent == stim.size() && rcvd == stim.size() && up_credits == IN_DEPTH))
            @(posedge clk);
        check_value("expected queue empty", 64'(exp_q.size()), 64'(0));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the converter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module i2f_tb -o i2f_sim

out=$(./obj_dir/i2f_sim)
printf '%s\n' "$out"

# Pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "Test OK"

// File: sim.f
source/i2f_pkg.sv
source/utility_log2.sv
source/mantissa_normalize.sv
source/credit_fifo.sv
source/credit_tracker.sv
source/i2f_pipeline.sv
source/i2f_top.sv
dv/i2f_tb.sv

// File: source/credit_fifo.sv
`timescale 1ns/10ps

module credit_fifo import i2f_pkg::*; #(
    parameter int LOG2_WIDTH = DEFAULT_LOG2_WIDTH,
    parameter int IN_DEPTH   = DEFAULT_IN_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic [2**LOG2_WIDTH-1:0] in_data,
    input  logic                     pop,
    output logic                     fifo_valid,
    output logic [2**LOG2_WIDTH-1:0] fifo_data,
    output logic                     in_credit
);

    localparam int WIDTH = 2 ** LOG2_WIDTH;
    localparam int PTR_W = cnt_width(IN_DEPTH - 1);
    localparam int CNT_W = cnt_width(IN_DEPTH);

    logic [WIDTH-1:0] mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap at IN_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(IN_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) wr_ptr <= ptr_next(wr_ptr);
            if (pop)      rd_ptr <= ptr_next(rd_ptr);
            case ({in_valid, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // Idle or push and pop together
            endcase
            in_credit <= pop;  // One credit back per word that leaves
        end
    end

    assign fifo_valid = (count != '0);
    assign fifo_data  = mem[rd_ptr];

    // ****************************************
    // Checks
    // ****************************************

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (count != CNT_W'(IN_DEPTH)))
        else $error("credit_fifo: write while full, upstream spent a credit it lacks");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> (count != '0))
        else $error("credit_fifo: pop while empty");

endmodule

// File: source/credit_tracker.sv
`timescale 1ns/10ps

module credit_tracker import i2f_pkg::*; #(
    parameter int OUT_CREDITS = DEFAULT_OUT_CREDITS
) (
    input  logic clk,
    input  logic reset,
    input  logic issue,
    input  logic out_credit,
    output logic grant
);

    localparam int CNT_W = cnt_width(OUT_CREDITS);

    logic [CNT_W-1:0] count;
    logic [CNT_W:0]   count_sum;  // Extra bit so an underflow shows up as a large value

    // Issue and return may land in the same cycle
    assign count_sum = {1'b0, count} + (CNT_W+1)'(out_credit) - (CNT_W+1)'(issue);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(OUT_CREDITS);
            grant <= 1'b0;
        end else begin
            count <= count_sum[CNT_W-1:0];
            grant <= (count_sum != '0);  // Tracks the updated count
        end
    end

    // ****************************************
    // Checks
    // ****************************************

    // Catches downstream returning more than it got as well as issue without a credit
    a_count_range: assert property (@(posedge clk) disable iff (reset)
        count_sum <= (CNT_W+1)'(OUT_CREDITS))
        else $error("credit_tracker: credit count out of range (%0d)", count_sum);

endmodule

// File: source/i2f_pipeline.sv
`timescale 1ns/10ps

module i2f_pipeline import i2f_pkg::*; #(
    parameter int LOG2_WIDTH = DEFAULT_LOG2_WIDTH,
    parameter int MANT_WIDTH = DEFAULT_MANT_WIDTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic [2**LOG2_WIDTH-1:0] in_data,
    output logic                     out_valid,
    output logic                     out_zero,
    output logic [LOG2_WIDTH-1:0]    out_exp,
    output logic [MANT_WIDTH-1:0]    out_mant
);

    localparam int WIDTH = 2 ** LOG2_WIDTH;

    logic [LOG2_WIDTH-1:0] log2_out;
    logic                  s1_valid;
    logic [WIDTH-1:0]      s1_data;
    logic [LOG2_WIDTH-1:0] s1_exp;
    logic                  s1_zero;
    logic [MANT_WIDTH-1:0] norm_mant;

    // ****************************************
    // Stage 1, leading-one detect
    // ****************************************

    utility_log2 #(
        .LOG2_WIDTH (LOG2_WIDTH)
    ) utility_log2_inst (
        .in  (in_data),
        .out (log2_out)  // Already 0 for a zero input
    );

    always_ff @(posedge clk) begin
        if (reset) s1_valid <= 1'b0;
        else       s1_valid <= in_valid;
        if (in_valid) begin
            s1_data <= in_data;
            s1_exp  <= log2_out;
            s1_zero <= (in_data == '0);
        end
    end

    // ****************************************
    // Stage 2, normalize
    // ****************************************

    mantissa_normalize #(
        .LOG2_WIDTH (LOG2_WIDTH),
        .MANT_WIDTH (MANT_WIDTH)
    ) mantissa_normalize_inst (
        .value (s1_data),
        .exp   (s1_exp),
        .mant  (norm_mant)
    );

    always_ff @(posedge clk) begin
        if (reset) out_valid <= 1'b0;
        else       out_valid <= s1_valid;
        if (s1_valid) begin
            out_zero <= s1_zero;
            out_exp  <= s1_exp;
            out_mant <= norm_mant;  // Zero input shifts to all zeros
        end
    end

endmodule

// File: source/i2f_pkg.sv
package i2f_pkg;

    // ****************************************
    // Default configuration
    // ****************************************

    // Data width is 2**LOG2_WIDTH, exponent width is LOG2_WIDTH
    localparam int DEFAULT_LOG2_WIDTH = 5;   // 32-bit integers

    localparam int DEFAULT_MANT_WIDTH = 8;   // Truncated mantissa bits

    localparam int DEFAULT_IN_DEPTH = 4;     // Input buffer slots = upstream credits

    localparam int DEFAULT_OUT_CREDITS = 4;  // Initial downstream credits

    // ****************************************
    // Helpers
    // ****************************************

    // Bits needed to hold any value 0..max_value, never less than 1
    function automatic int cnt_width(input int max_value);
        int width;
        width = 1;
        while ((2 ** width) <= max_value) begin
            width = width + 1;
        end
        return width;
    endfunction

endpackage

// File: source/i2f_top.sv
`timescale 1ns/10ps

module i2f_top import i2f_pkg::*; #(
    parameter int LOG2_WIDTH  = DEFAULT_LOG2_WIDTH,
    parameter int MANT_WIDTH  = DEFAULT_MANT_WIDTH,
    parameter int IN_DEPTH    = DEFAULT_IN_DEPTH,
    parameter int OUT_CREDITS = DEFAULT_OUT_CREDITS
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic [2**LOG2_WIDTH-1:0] in_data,
    input  logic                     out_credit,
    output logic                     in_credit,
    output logic                     out_valid,
    output logic                     out_zero,
    output logic [LOG2_WIDTH-1:0]    out_exp,
    output logic [MANT_WIDTH-1:0]    out_mant
);

    logic                     fifo_valid;
    logic [2**LOG2_WIDTH-1:0] fifo_data;
    logic                     grant;
    logic                     pop;

    // Downstream credit is reserved here, so the pipeline never stalls
    assign pop = fifo_valid & grant;

    credit_fifo #(
        .LOG2_WIDTH (LOG2_WIDTH),
        .IN_DEPTH   (IN_DEPTH)
    ) credit_fifo_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .pop        (pop),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .in_credit  (in_credit)
    );

    credit_tracker #(
        .OUT_CREDITS (OUT_CREDITS)
    ) credit_tracker_inst (
        .clk        (clk),
        .reset      (reset),
        .issue      (pop),
        .out_credit (out_credit),
        .grant      (grant)
    );

    i2f_pipeline #(
        .LOG2_WIDTH (LOG2_WIDTH),
        .MANT_WIDTH (MANT_WIDTH)
    ) i2f_pipeline_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pop),
        .in_data   (fifo_data),
        .out_valid (out_valid),
        .out_zero  (out_zero),
        .out_exp   (out_exp),
        .out_mant  (out_mant)
    );

endmodule

// File: source/mantissa_normalize.sv
`timescale 1ns/10ps

module mantissa_normalize import i2f_pkg::*; #(
    parameter int LOG2_WIDTH = DEFAULT_LOG2_WIDTH,
    parameter int MANT_WIDTH = DEFAULT_MANT_WIDTH
) (
    input  logic [2**LOG2_WIDTH-1:0] value,
    input  logic [LOG2_WIDTH-1:0]    exp,
    output logic [MANT_WIDTH-1:0]    mant
);

    localparam int WIDTH = 2 ** LOG2_WIDTH;

    logic [LOG2_WIDTH-1:0] shift_amt;
    logic [WIDTH-1:0]      shifted;

    if (MANT_WIDTH > WIDTH) begin : g_bad_mant
        $error("mantissa_normalize: MANT_WIDTH %0d exceeds data width %0d",
               MANT_WIDTH, WIDTH);
    end

    // WIDTH-1 is all ones in LOG2_WIDTH bits, so WIDTH-1-exp is ~exp
    assign shift_amt = ~exp;

    assign shifted = value << shift_amt;  // Leading one lands on the MSB

    // Truncate, lower bits are dropped
    assign mant = shifted[WIDTH-1 -: MANT_WIDTH];

    // ****************************************
    // Checks
    // ****************************************

    // Holds only if exp really is floor(log2(value)) from the detector
    always_comb begin
        if (value != '0) begin
            a_norm_msb: assert final (mant[MANT_WIDTH-1])
                else $error("mantissa_normalize: value %0h exp %0d left MSB clear",
                            value, exp);
        end
    end

endmodule

// File: source/utility_log2.sv
`timescale 1ns/10ps

module utility_log2 import i2f_pkg::*; #(
    parameter int LOG2_WIDTH = DEFAULT_LOG2_WIDTH
) (
    input  logic [2**LOG2_WIDTH-1:0] in,
    output logic [LOG2_WIDTH-1:0]    out
);

    localparam int WIDTH = 2 ** LOG2_WIDTH;

    // Partial value and accumulated exponent, index = stage
    logic [WIDTH-1:0]      part [LOG2_WIDTH:2];
    logic [LOG2_WIDTH-1:0] acc  [LOG2_WIDTH:2];
    logic [1:0]            low;

    if (LOG2_WIDTH < 2 || LOG2_WIDTH > 7) begin : g_bad_width
        $error("utility_log2: LOG2_WIDTH %0d outside 2..7", LOG2_WIDTH);
    end

    assign part[LOG2_WIDTH] = in;
    assign acc[LOG2_WIDTH]  = '0;

    // ****************************************
    // Halving stages
    // ****************************************

    // Each stage looks at the upper half of what is left, keeps that half
    // if it holds a one and adds its offset to the exponent
    for (genvar s = LOG2_WIDTH - 1; s >= 2; s = s - 1) begin : g_stage
        localparam int HALF = 2 ** s;

        logic [WIDTH-1:0] upper;
        logic             hit;

        assign upper = part[s+1] >> HALF;
        assign hit   = (upper != '0);

        assign part[s] = hit ? upper : part[s+1];
        assign acc[s]  = hit ? acc[s+1] + LOG2_WIDTH'(HALF) : acc[s+1];
    end

    // ****************************************
    // Last nibble
    // ****************************************

    always_comb begin
        casez (part[2][3:0])
            4'b1???: low = 2'd3;
            4'b01??: low = 2'd2;
            4'b001?: low = 2'd1;
            default: low = 2'd0;  // 0 and 1 both give 0
        endcase
    end

    assign out = acc[2] + LOG2_WIDTH'(low);

endmodule
